//--- run_sim.sh
#!/bin/sh
# compile and run the issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_iq_top -f tb.f -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- src/iq_age_matrix.sv
`default_nettype none

module iq_age_matrix #(
    parameter int iq_depth = 8
) (
    input  logic                clock,
    input  logic                reset_n,
    input  logic [iq_depth-1:0] entry_valid,
    input  logic [iq_depth-1:0] entry_ready,   // valid and nothing pending
    input  logic [iq_depth-1:0] alloc_oh,      // slot written this cycle
    input  logic [iq_depth-1:0] free_oh,       // slot issued this cycle
    output logic                oldest_found,
    output logic [iq_depth-1:0] oldest_oh
);

    localparam int idx_w = $clog2(iq_depth);

    // age[i][j] set -> entry i older than entry j, diagonal stays 0
    logic [iq_depth-1:0][iq_depth-1:0] age;
    logic [iq_depth-1:0]               older_ready;  // some older ready entry exists
    logic [idx_w-1:0]                  alloc_idx;
    logic [idx_w-1:0]                  free_idx;

    // one-hot to index, input assumed one-hot or zero
    function automatic logic [idx_w-1:0] oh_to_idx(input logic [iq_depth-1:0] oh);
        logic [idx_w-1:0] idx;
        idx = '0;
        for (int k = 0; k < iq_depth; k++) begin
            if (oh[k]) begin
                idx = idx | idx_w'(k);
            end
        end
        return idx;
    endfunction

    assign alloc_idx = oh_to_idx(alloc_oh);
    assign free_idx  = oh_to_idx(free_oh);

    // --------------------
    // oldest ready select
    // --------------------
    always_comb begin
        for (int i = 0; i < iq_depth; i++) begin
            older_ready[i] = 1'b0;
            // scan column i for a ready row that beats it
            for (int j = 0; j < iq_depth; j++) begin
                if (age[j][i] && entry_ready[j]) begin
                    older_ready[i] = 1'b1;
                end
            end
        end
    end

    assign oldest_oh    = entry_ready & ~older_ready;   // at most one survives
    assign oldest_found = |oldest_oh;

    // --------------------
    // matrix update
    // --------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            age <= '0;
        end else begin
            if (|alloc_oh) begin
                for (int j = 0; j < iq_depth; j++) begin
                    age[j][alloc_idx] <= entry_valid[j];  // every live entry is older
                    age[alloc_idx][j] <= 1'b0;            // new entry older than none
                end
            end
            // free comes second so a slot leaving this cycle
            // does not keep a stale bit over the new one
            if (|free_oh) begin
                for (int j = 0; j < iq_depth; j++) begin
                    age[free_idx][j] <= 1'b0;
                    age[j][free_idx] <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // checks
    // --------------------
    // ordering must be total among ready entries
    a_oldest_onehot: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(oldest_oh));

    // queue must only write into an empty slot
    a_alloc_free_slot: assert property (@(posedge clock) disable iff (!reset_n)
        (alloc_oh & entry_valid) == '0);

endmodule

`default_nettype wire

//--- src/iq_dispatch.sv
`default_nettype none

module iq_dispatch
    import iq_pkg::*;
(
    input  logic             clock,
    input  logic             reset_n,
    input  logic             in_valid,
    input  uop_t             in_uop,
    output logic             in_ready,
    output logic             enq_valid,
    output uop_t             enq_uop,
    output logic             enq_src1_pend,
    output logic             enq_src2_pend,
    input  logic             enq_ready,
    input  logic             wb_valid,    // wakeup from execute
    input  logic [tag_w-1:0] wb_tag
);

    logic [n_tags-1:0] busy;              // tag has a producer in flight
    logic              accept;
    logic [tag_w-1:0]  src2_tag;
    logic              src1_woken;
    logic              src2_woken;

    assign in_ready  = enq_ready;         // queue decides
    assign enq_valid = in_valid;
    assign enq_uop   = in_uop;
    assign accept    = in_valid && enq_ready;

    // --------------------
    // pending calc
    // --------------------
    assign src2_tag   = in_uop.src.rr_src2;
    assign src1_woken = wb_valid && (wb_tag == in_uop.src1);  // same-cycle bypass
    assign src2_woken = wb_valid && (wb_tag == src2_tag);

    assign enq_src1_pend = busy[in_uop.src1] && !src1_woken;
    // ri form: field is an immediate, nothing to wait for
    assign enq_src2_pend = (in_uop.op == op_ri) ? 1'b0 : (busy[src2_tag] && !src2_woken);

    // --------------------
    // busy table
    // --------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_tag] <= 1'b0;
            end
            if (accept) begin
                busy[in_uop.dst] <= 1'b1;     // new producer wins over a clear
            end
        end
    end

    // execute only completes what dispatch marked busy
    a_wb_busy: assert property (@(posedge clock) disable iff (!reset_n)
        wb_valid |-> busy[wb_tag]);

endmodule

`default_nettype wire

//--- src/iq_exec_pipe.sv
`default_nettype none

module iq_exec_pipe
    import iq_pkg::*;
#(
    parameter int exec_lat = 3
) (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             iss_valid,   // always taken
    input  uop_t             iss_uop,
    output logic             wb_valid,
    output logic [tag_w-1:0] wb_tag,
    output logic             done_valid,
    output logic [tag_w-1:0] done_tag,
    output logic [seq_w-1:0] done_seq
);

    // --------------------
    // stage registers
    // --------------------
    logic [exec_lat-1:0] vld;             // one bit per stage
    logic [tag_w-1:0]    dst_q [exec_lat];
    logic [seq_w-1:0]    seq_q [exec_lat];

    // valid chain, reset so nothing fires out of reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            vld <= '0;
        end else begin
            vld[0] <= iss_valid;
            for (int k = 1; k < exec_lat; k++) begin
                vld[k] <= vld[k-1];
            end
        end
    end

    // payload moves with its valid
    always_ff @(posedge clock) begin
        dst_q[0] <= iss_uop.dst;
        seq_q[0] <= iss_uop.seq;
        for (int k = 1; k < exec_lat; k++) begin
            dst_q[k] <= dst_q[k-1];
            seq_q[k] <= seq_q[k-1];
        end
    end

    // --------------------
    // last stage out
    // --------------------
    assign wb_valid   = vld[exec_lat-1];     // wakes dispatch and queue
    assign wb_tag     = dst_q[exec_lat-1];
    assign done_valid = vld[exec_lat-1];     // completion report
    assign done_tag   = dst_q[exec_lat-1];
    assign done_seq   = seq_q[exec_lat-1];

endmodule

`default_nettype wire

//--- src/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int tag_w  = 4;            // physical tag width
    localparam int n_tags = 1 << tag_w;   // 16 tags
    localparam int seq_w  = 8;            // dispatch sequence stamp
    localparam int imm_w  = 4;            // ri immediate, shares the src2 field

    // opcode encodings
    localparam logic op_rr = 1'b0;        // reg-reg, two sources
    localparam logic op_ri = 1'b1;        // reg-imm, src1 only

    // --------------------
    // micro-op word
    // --------------------
    // same 4 bits, two meanings depending on op
    typedef union packed {
        logic [tag_w-1:0] rr_src2;        // second source tag
        logic [imm_w-1:0] ri_imm;         // immediate, never waited on
    } uop_src_u;

    typedef struct packed {
        logic             op;
        logic [tag_w-1:0] dst;
        logic [tag_w-1:0] src1;
        uop_src_u         src;
        logic [seq_w-1:0] seq;
    } uop_t;                              // 21 bits

endpackage

`default_nettype wire

//--- src/iq_top.sv
`default_nettype none

module iq_top
    import iq_pkg::*;
#(
    parameter int iq_depth = 8,
    parameter int exec_lat = 3
) (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             in_valid,
    input  uop_t             in_uop,
    output logic             in_ready,
    output logic             done_valid,
    output logic [tag_w-1:0] done_tag,
    output logic [seq_w-1:0] done_seq
);

    // --------------------
    // internal links
    // --------------------
    logic             enq_valid;
    logic             enq_ready;
    uop_t             enq_uop;
    logic             enq_src1_pend;
    logic             enq_src2_pend;
    logic             iss_valid;      // no ready, pipe always takes it
    uop_t             iss_uop;
    logic             wb_valid;       // wakeup broadcast
    logic [tag_w-1:0] wb_tag;

    iq_dispatch u_dispatch (
        .clock         (clock),
        .reset_n       (reset_n),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_ready      (in_ready),
        .enq_valid     (enq_valid),
        .enq_uop       (enq_uop),
        .enq_src1_pend (enq_src1_pend),
        .enq_src2_pend (enq_src2_pend),
        .enq_ready     (enq_ready),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag)
    );

    issue_queue #(
        .iq_depth (iq_depth)
    ) u_queue (
        .clock         (clock),
        .reset_n       (reset_n),
        .enq_valid     (enq_valid),
        .enq_uop       (enq_uop),
        .enq_src1_pend (enq_src1_pend),
        .enq_src2_pend (enq_src2_pend),
        .enq_ready     (enq_ready),
        .iss_valid     (iss_valid),
        .iss_uop       (iss_uop),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag)
    );

    iq_exec_pipe #(
        .exec_lat (exec_lat)
    ) u_exec (
        .clock      (clock),
        .reset_n    (reset_n),
        .iss_valid  (iss_valid),
        .iss_uop    (iss_uop),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .done_valid (done_valid),
        .done_tag   (done_tag),
        .done_seq   (done_seq)
    );

endmodule

`default_nettype wire

//--- src/issue_queue.sv
`default_nettype none

module issue_queue
    import iq_pkg::*;
#(
    parameter int iq_depth = 8
) (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             enq_valid,
    input  uop_t             enq_uop,
    input  logic             enq_src1_pend,
    input  logic             enq_src2_pend,
    output logic             enq_ready,
    output logic             iss_valid,
    output uop_t             iss_uop,
    input  logic             wb_valid,
    input  logic [tag_w-1:0] wb_tag
);

    // --------------------
    // entry state
    // --------------------
    logic [iq_depth-1:0] valid;
    logic [iq_depth-1:0] pend1;           // src1 still waiting
    logic [iq_depth-1:0] pend2;           // src2 still waiting, rr only
    uop_t                uops [iq_depth]; // payload

    logic                out_of_reset;    // holds enq_ready low through reset
    logic [iq_depth-1:0] free_slots;
    logic [iq_depth-1:0] lowest_free;
    logic [iq_depth-1:0] alloc_oh;
    logic [iq_depth-1:0] entry_ready;
    logic [iq_depth-1:0] oldest_oh;
    logic                oldest_found;

    assign free_slots  = ~valid;
    assign lowest_free = free_slots & (~free_slots + 1'b1);  // isolate lowest set bit
    assign enq_ready   = out_of_reset && (|free_slots);
    assign alloc_oh    = (enq_valid && enq_ready) ? lowest_free : '0;
    assign entry_ready = valid & ~pend1 & ~pend2;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    // --------------------
    // age ordering
    // --------------------
    iq_age_matrix #(
        .iq_depth (iq_depth)
    ) u_age (
        .clock        (clock),
        .reset_n      (reset_n),
        .entry_valid  (valid),
        .entry_ready  (entry_ready),
        .alloc_oh     (alloc_oh),
        .free_oh      (oldest_oh),        // pipe never refuses, issue == free
        .oldest_found (oldest_found),
        .oldest_oh    (oldest_oh)
    );

    // issue mux, one-hot select
    always_comb begin
        iss_uop = '0;
        for (int i = 0; i < iq_depth; i++) begin
            if (oldest_oh[i]) begin
                iss_uop = iss_uop | uops[i];
            end
        end
    end

    assign iss_valid = oldest_found;

    // --------------------
    // valid / pending update
    // --------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid <= '0;
            pend1 <= '0;
            pend2 <= '0;
        end else begin
            for (int i = 0; i < iq_depth; i++) begin
                if (alloc_oh[i]) begin
                    valid[i] <= 1'b1;
                    pend1[i] <= enq_src1_pend;   // dispatch already bypassed wb
                    pend2[i] <= enq_src2_pend;
                end else if (oldest_oh[i]) begin
                    valid[i] <= 1'b0;            // leaves on the issue edge
                end else if (valid[i] && wb_valid) begin
                    if (wb_tag == uops[i].src1) begin
                        pend1[i] <= 1'b0;
                    end
                    // field is an immediate in ri form
                    if (uops[i].op == op_rr && wb_tag == uops[i].src.rr_src2) begin
                        pend2[i] <= 1'b0;
                    end
                end
            end
        end
    end

    // payload only written on alloc
    always_ff @(posedge clock) begin
        for (int i = 0; i < iq_depth; i++) begin
            if (alloc_oh[i]) begin
                uops[i] <= enq_uop;
            end
        end
    end

    // age matrix choice must agree with the stored pending bits
    a_issue_ready: assert property (@(posedge clock) disable iff (!reset_n)
        iss_valid |-> ((oldest_oh & (pend1 | pend2 | ~valid)) == '0));

endmodule

`default_nettype wire

//--- tb.f
src/iq_pkg.sv
src/iq_age_matrix.sv
src/iq_dispatch.sv
src/issue_queue.sv
src/iq_exec_pipe.sv
src/iq_top.sv
test/tb_iq_top.sv

//--- test/tb_iq_top.sv
`default_nettype none

module tb_iq_top
    import iq_pkg::*;
();

    localparam int iq_depth  = 8;
    localparam int exec_lat  = 3;
    localparam int n_rows    = 38;
    localparam int drive_dly = 10;    // input skew after the rising edge
    localparam int exp_stall = 3;     // cycles the full queue holds off dispatch
    localparam int wd_cycles = n_rows * (exec_lat + iq_depth + 4) + 100;

    logic             clock;
    logic             reset_n;
    logic             in_valid;
    uop_t             in_uop;
    logic             in_ready;
    logic             done_valid;
    logic [tag_w-1:0] done_tag;
    logic [seq_w-1:0] done_seq;

    // --------------------
    // stimulus table
    // --------------------
    uop_t stim [n_rows];              // row index doubles as seq
    int   grp  [n_rows];              // test group drained before the next starts
    int   n_loaded     = 0;
    int   done_count   = 0;
    int   stall_cycles = 0;

    // completion order by seq under the oldest-ready rule
    int exp_order [n_rows] = '{
        0, 1, 2, 3, 4, 5, 6, 7,                   // independent stream
        8, 9, 12, 13, 14, 10, 11,                 // 10 and 11 wait on the chain
        15, 17, 16, 18,                           // ri skips while rr waits
        19, 20, 21, 22, 23, 24, 25, 26, 27, 28,   // full queue drains after the chain
        29, 30, 31,
        32, 35, 33, 34, 36, 37                    // woken together and issued by age
    };

    iq_top #(
        .iq_depth (iq_depth),
        .exec_lat (exec_lat)
    ) UUT (
        .clock      (clock),
        .reset_n    (reset_n),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .done_valid (done_valid),
        .done_tag   (done_tag),
        .done_seq   (done_seq)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // fld is the src2 tag in rr form and the immediate in ri form
    task automatic add_row(input int g, input logic op, input int dst, input int s1,
                           input int fld);
        uop_t u;
        u      = '0;
        u.op   = op;
        u.dst  = tag_w'(dst);
        u.src1 = tag_w'(s1);
        if (op == op_ri) begin
            u.src.ri_imm = imm_w'(fld);
        end else begin
            u.src.rr_src2 = tag_w'(fld);
        end
        u.seq = seq_w'(n_loaded);
        stim[n_loaded] = u;
        grp[n_loaded]  = g;
        n_loaded++;
    endtask

    // tags 14 and 15 are never written so always ready
    task automatic load_table();
        for (int k = 0; k < 8; k++) begin
            add_row(1, op_rr, 1 + k, 14, 15);
        end
        add_row(2, op_rr, 1, 14, 15);     // chain head
        add_row(2, op_rr, 2, 1, 15);
        add_row(2, op_rr, 3, 2, 15);
        add_row(2, op_rr, 4, 3, 15);      // reads chain end
        add_row(2, op_rr, 5, 1, 15);      // tag 1 wakes in its dispatch cycle
        add_row(2, op_rr, 6, 14, 15);
        add_row(2, op_rr, 7, 15, 14);
        add_row(3, op_rr, 1, 14, 15);
        add_row(3, op_rr, 2, 1, 15);      // tag 2 busy for a while
        add_row(3, op_ri, 3, 14, 2);      // imm equals busy tag
        add_row(3, op_rr, 4, 14, 2);      // same field as a real source
        add_row(4, op_rr, 1, 14, 15);
        add_row(4, op_rr, 2, 1, 15);
        add_row(4, op_rr, 3, 2, 15);      // long chain end
        for (int k = 0; k < 10; k++) begin
            add_row(4, op_rr, 4 + k, 3, 14);
        end
        add_row(5, op_rr, 1, 14, 15);
        add_row(5, op_rr, 2, 1, 15);
        add_row(5, op_rr, 3, 14, 2);
        add_row(5, op_rr, 4, 15, 14);     // frees a low slot early
        add_row(5, op_rr, 5, 14, 2);
        add_row(5, op_rr, 6, 2, 14);      // lands below the older entry
    endtask

    // wait for target completions and re-align to the drive point
    task automatic wait_drain(input int target);
        while (done_count < target) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        #drive_dly;
    endtask

    // --------------------
    // completion monitor
    // --------------------
    always @(negedge clock) begin
        if (!reset_n) begin
            check_value("done_valid", 32'(done_valid), 32'd0);
            check_value("in_ready", 32'(in_ready), 32'd0);   // low through reset
        end else begin
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end
            if (done_valid) begin
                if (done_count >= n_rows) begin
                    $display("error: extra completion after the last one, seq %h", done_seq);
                    $display("sim failed");
                    $fatal(1);
                end else begin
                    check_value("done_seq", 32'(done_seq), 32'(exp_order[done_count]));
                    check_value("done_tag", 32'(done_tag),
                                32'(stim[exp_order[done_count]].dst));
                    done_count++;
                end
            end
        end
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        repeat (wd_cycles) @(posedge clock);
        $display("error: timeout, completions never finished (%0d of %0d seen)",
                 done_count, n_rows);
        $display("sim failed");
        $fatal(1);
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset_n  = 1'b0;
        in_valid = 1'b0;
        in_uop   = '0;
        load_table();
        repeat (8) @(posedge clock);
        #drive_dly;
        reset_n = 1'b1;
        @(posedge clock);                 // queue leaves reset here
        @(negedge clock);
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_value("done_valid", 32'(done_valid), 32'd0);
        @(posedge clock);
        #drive_dly;
        for (int r = 0; r < n_rows; r++) begin
            if (r > 0 && grp[r] != grp[r-1]) begin
                wait_drain(r);            // each group starts from an empty queue
            end
            in_valid = 1'b1;
            in_uop   = stim[r];
            do begin
                @(negedge clock);         // in_ready settled mid-cycle
            end while (!in_ready);
            @(posedge clock);
            #drive_dly;
            in_valid = 1'b0;
        end
        wait_drain(n_rows);
        repeat (exec_lat + 4) @(posedge clock);   // room for a stray completion
        check_value("stall_cycles", 32'(stall_cycles), 32'(exp_stall));
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
